// File: source/comp_pkg.sv
`default_nettype none

package comp_pkg;

   typedef logic [31:0] word_t;

   // Remainder code on the last payload word, low-order bytes invalid
   // 0000 four bytes, 0001 three, 0011 two, 0111 one
   typedef logic [3:0] rem_t;

   typedef logic [2:0] flag_t;
   typedef logic [9:0] task_t;
   typedef logic [31:0] byte_cnt_t;

   // Header layout
   localparam int HDR_WORDS = 8;
   localparam int HDR_FLAG_IDX = 4;
   localparam int HDR_LEN_IDX = 5;
   localparam int HDR_TASK_IDX = 6;

   // Trailer layout
   localparam int TRL_WORDS = 4;
   localparam word_t TRL_MARKER = 32'haa5555aa;

   // CRC-32, MSB first, non-reflected, no final inversion
   localparam word_t CRC_POLY = 32'h04C11DB7;
   localparam word_t CRC_INIT = 32'hffffffff;

endpackage

`default_nettype wire

// File: source/frame_ctrl.sv
`default_nettype none

module frame_ctrl (
   input  logic clk,
   input  logic rst_n,
   input  logic in_sof_n_i,
   input  logic in_eof_n_i,
   input  logic in_src_rdy_n_i,
   output logic in_dst_rdy_n_o,
   input  logic out_dst_rdy_n_i,
   output logic out_src_rdy_n_o,
   output logic out_sof_n_o,
   output logic out_eof_n_o,
   input  logic hdr_last_i,
   input  logic trl_last_i,
   input  logic fifo_empty_i,
   input  logic fifo_full_i,
   output logic hdr_beat_o,
   output logic pay_beat_o,
   output logic trl_beat_o,
   output logic pop_o,
   output logic trailer_sel_o,
   output logic frame_clear_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_HDR,
      S_PAY,
      S_TRL
   } state_t;

   state_t state;
   state_t state_nxt;
   logic   in_take;
   logic   out_take;
   logic   eof_seen;
   logic   first_sent;

   // Idle takes any offered word and drops it unless it starts a frame
   always_comb begin
      case (state)
         S_IDLE:  in_dst_rdy_n_o = in_src_rdy_n_i;
         S_HDR:   in_dst_rdy_n_o = 1'b0;
         S_PAY:   in_dst_rdy_n_o = eof_seen | fifo_full_i;
         default: in_dst_rdy_n_o = 1'b1;
      endcase
   end

   assign in_take = !in_src_rdy_n_i && !in_dst_rdy_n_o;
   assign out_src_rdy_n_o = !(((state == S_PAY) && !fifo_empty_i) || (state == S_TRL));
   assign out_take = !out_src_rdy_n_o && !out_dst_rdy_n_i;

   assign hdr_beat_o = in_take && (((state == S_IDLE) && !in_sof_n_i) || (state == S_HDR));
   assign pay_beat_o = in_take && (state == S_PAY);
   assign pop_o = out_take && (state == S_PAY);
   assign trl_beat_o = out_take && (state == S_TRL);
   assign trailer_sel_o = (state == S_TRL);
   // Marker taken, frame done
   assign frame_clear_o = trl_beat_o && trl_last_i;

   assign out_sof_n_o = !((state == S_PAY) && !first_sent && !fifo_empty_i);
   assign out_eof_n_o = !((state == S_TRL) && trl_last_i);

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE: begin
            if (hdr_beat_o)
               state_nxt = S_HDR;
         end
         S_HDR: begin
            if (hdr_beat_o && hdr_last_i)
               state_nxt = S_PAY;
         end
         S_PAY: begin
            // Drain FIFO before the trailer
            if (eof_seen && fifo_empty_i)
               state_nxt = S_TRL;
         end
         default: begin
            if (frame_clear_o)
               state_nxt = S_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= S_IDLE;
         eof_seen <= 1'b0;
         first_sent <= 1'b0;
      end else begin
         state <= state_nxt;
         if (frame_clear_o) begin
            eof_seen <= 1'b0;
            first_sent <= 1'b0;
         end else begin
            if (pay_beat_o && !in_eof_n_i)
               eof_seen <= 1'b1;
            if (pop_o)
               first_sent <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/beat_counter.sv
`default_nettype none

module beat_counter (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                frame_clear_i,
   input  logic                hdr_beat_i,
   input  logic                trl_beat_i,
   input  logic                pay_beat_i,
   input  logic                in_eof_n_i,
   input  comp_pkg::rem_t      in_rem_i,
   output logic [2:0]          hdr_idx_o,
   output logic                hdr_last_o,
   output logic [1:0]          trl_idx_o,
   output logic                trl_last_o,
   output comp_pkg::byte_cnt_t byte_cnt_o
);

   import comp_pkg::*;

   byte_cnt_t beat_bytes;

   // Bytes carried by the current payload word
   always_comb begin
      beat_bytes = 32'd4;
      if (!in_eof_n_i) begin
         case (in_rem_i)
            4'b0001: beat_bytes = 32'd3;
            4'b0011: beat_bytes = 32'd2;
            4'b0111: beat_bytes = 32'd1;
            default: beat_bytes = 32'd4;
         endcase
      end
   end

   assign hdr_last_o = (hdr_idx_o == 3'(HDR_WORDS - 1));
   assign trl_last_o = (trl_idx_o == 2'(TRL_WORDS - 1));

   // Indices wrap on their last word
   always_ff @(posedge clk) begin
      if (!rst_n || frame_clear_i) begin
         hdr_idx_o <= '0;
         trl_idx_o <= '0;
         byte_cnt_o <= '0;
      end else begin
         if (hdr_beat_i)
            hdr_idx_o <= hdr_idx_o + 3'd1;
         if (trl_beat_i)
            trl_idx_o <= trl_idx_o + 2'd1;
         if (pay_beat_i)
            byte_cnt_o <= byte_cnt_o + beat_bytes;
      end
   end

endmodule

`default_nettype wire

// File: source/payload_fifo.sv
`default_nettype none

module payload_fifo #(
   parameter int DEPTH = 8
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            push_i,
   input  comp_pkg::word_t push_data_i,
   input  logic            pop_i,
   output comp_pkg::word_t head_o,
   output logic            empty_o,
   output logic            full_o
);

   import comp_pkg::*;

   localparam int AW = $clog2(DEPTH);

   word_t         mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW-1:0] wr_ptr_nxt;
   logic          occ_full;
   logic          ptr_eq;
   logic          do_push;
   logic          do_pop;

   // Equal pointers mean empty or full, the flag tells which
   assign ptr_eq = (wr_ptr == rd_ptr);
   assign empty_o = ptr_eq && !occ_full;
   assign full_o = ptr_eq && occ_full;

   assign do_push = push_i && !full_o;
   assign do_pop = pop_i && !empty_o;
   assign wr_ptr_nxt = wr_ptr + 1'b1;

   assign head_o = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= push_data_i;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         occ_full <= 1'b0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr_nxt;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_push && !do_pop)
            occ_full <= (wr_ptr_nxt == rd_ptr);
         else if (do_pop && !do_push)
            occ_full <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: source/crc32_acc.sv
`default_nettype none

module crc32_acc (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            clear_i,
   input  logic            acc_i,
   input  comp_pkg::word_t data_i,
   output comp_pkg::word_t crc_o
);

   import comp_pkg::*;

   // One word per call, data MSB first
   function automatic word_t crc_step(input word_t crc, input word_t data);
      word_t c;
      c = crc;
      for (int i = 31; i >= 0; i--) begin
         if (c[31] ^ data[i])
            c = {c[30:0], 1'b0} ^ CRC_POLY;
         else
            c = {c[30:0], 1'b0};
      end
      return c;
   endfunction

   always_ff @(posedge clk) begin
      if (!rst_n || clear_i)
         crc_o <= CRC_INIT;
      else if (acc_i)
         crc_o <= crc_step(crc_o, data_i);
   end

endmodule

`default_nettype wire

// File: source/trailer_builder.sv
`default_nettype none

module trailer_builder (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                hdr_beat_i,
   input  logic [2:0]          hdr_idx_i,
   input  comp_pkg::word_t     in_data_i,
   input  comp_pkg::byte_cnt_t byte_cnt_i,
   input  comp_pkg::word_t     crc_i,
   input  logic [1:0]          trl_idx_i,
   output comp_pkg::word_t     trailer_o
);

   import comp_pkg::*;

   flag_t     flags_q;
   task_t     task_q;
   byte_cnt_t len_q;
   logic      cpl;
   word_t     status_word;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         flags_q <= '0;
         task_q <= '0;
         len_q <= '0;
      end else if (hdr_beat_i) begin
         if (hdr_idx_i == 3'(HDR_FLAG_IDX))
            flags_q <= in_data_i[31:29];
         if (hdr_idx_i == 3'(HDR_LEN_IDX))
            len_q <= in_data_i;
         if (hdr_idx_i == 3'(HDR_TASK_IDX))
            task_q <= in_data_i[9:0];
      end
   end

   // Frame complete when the counted bytes match the header length
   assign cpl = (byte_cnt_i == len_q);

   // Status: flags 31..29, completion 28, task 9..0
   assign status_word = {flags_q, cpl, 18'd0, task_q};

   always_comb begin
      case (trl_idx_i)
         2'd0:    trailer_o = status_word;
         2'd1:    trailer_o = byte_cnt_i;
         2'd2:    trailer_o = crc_i;
         default: trailer_o = TRL_MARKER;
      endcase
   end

endmodule

`default_nettype wire

// File: source/comp_unit.sv
`default_nettype none

module comp_unit #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic            clk,
   input  logic            rst_n,
   input  comp_pkg::word_t in_data_i,
   input  comp_pkg::rem_t  in_rem_i,
   input  logic            in_sof_n_i,
   input  logic            in_eof_n_i,
   input  logic            in_src_rdy_n_i,
   output logic            in_dst_rdy_n_o,
   output comp_pkg::word_t out_data_o,
   output logic            out_sof_n_o,
   output logic            out_eof_n_o,
   output logic            out_src_rdy_n_o,
   input  logic            out_dst_rdy_n_i
);

   import comp_pkg::*;

   logic      hdr_beat;
   logic      pay_beat;
   logic      trl_beat;
   logic      pop;
   logic      trailer_sel;
   logic      frame_clear;
   logic [2:0] hdr_idx;
   logic      hdr_last;
   logic [1:0] trl_idx;
   logic      trl_last;
   logic      fifo_empty;
   logic      fifo_full;
   word_t     push_data;
   word_t     fifo_head;
   word_t     crc;
   word_t     trailer_word;
   byte_cnt_t byte_cnt;

   // Zero the invalid low bytes of the last payload word
   always_comb begin
      push_data = in_data_i;
      if (!in_eof_n_i) begin
         case (in_rem_i)
            4'b0001: push_data = {in_data_i[31:8], 8'h00};
            4'b0011: push_data = {in_data_i[31:16], 16'h0000};
            4'b0111: push_data = {in_data_i[31:24], 24'h000000};
            default: push_data = in_data_i;
         endcase
      end
   end

   assign out_data_o = trailer_sel ? trailer_word : fifo_head;

   frame_ctrl u_frame_ctrl (
      .clk             (clk),
      .rst_n           (rst_n),
      .in_sof_n_i      (in_sof_n_i),
      .in_eof_n_i      (in_eof_n_i),
      .in_src_rdy_n_i  (in_src_rdy_n_i),
      .in_dst_rdy_n_o  (in_dst_rdy_n_o),
      .out_dst_rdy_n_i (out_dst_rdy_n_i),
      .out_src_rdy_n_o (out_src_rdy_n_o),
      .out_sof_n_o     (out_sof_n_o),
      .out_eof_n_o     (out_eof_n_o),
      .hdr_last_i      (hdr_last),
      .trl_last_i      (trl_last),
      .fifo_empty_i    (fifo_empty),
      .fifo_full_i     (fifo_full),
      .hdr_beat_o      (hdr_beat),
      .pay_beat_o      (pay_beat),
      .trl_beat_o      (trl_beat),
      .pop_o           (pop),
      .trailer_sel_o   (trailer_sel),
      .frame_clear_o   (frame_clear)
   );

   beat_counter u_beat_counter (
      .clk           (clk),
      .rst_n         (rst_n),
      .frame_clear_i (frame_clear),
      .hdr_beat_i    (hdr_beat),
      .trl_beat_i    (trl_beat),
      .pay_beat_i    (pay_beat),
      .in_eof_n_i    (in_eof_n_i),
      .in_rem_i      (in_rem_i),
      .hdr_idx_o     (hdr_idx),
      .hdr_last_o    (hdr_last),
      .trl_idx_o     (trl_idx),
      .trl_last_o    (trl_last),
      .byte_cnt_o    (byte_cnt)
   );

   payload_fifo #(
      .DEPTH (FIFO_DEPTH)
   ) u_payload_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .push_i      (pay_beat),
      .push_data_i (push_data),
      .pop_i       (pop),
      .head_o      (fifo_head),
      .empty_o     (fifo_empty),
      .full_o      (fifo_full)
   );

   // CRC runs over the words as they leave
   crc32_acc u_crc32_acc (
      .clk     (clk),
      .rst_n   (rst_n),
      .clear_i (frame_clear),
      .acc_i   (pop),
      .data_i  (fifo_head),
      .crc_o   (crc)
   );

   trailer_builder u_trailer_builder (
      .clk        (clk),
      .rst_n      (rst_n),
      .hdr_beat_i (hdr_beat),
      .hdr_idx_i  (hdr_idx),
      .in_data_i  (in_data_i),
      .byte_cnt_i (byte_cnt),
      .crc_i      (crc),
      .trl_idx_i  (trl_idx),
      .trailer_o  (trailer_word)
   );

endmodule

`default_nettype wire

// File: bench/comp_unit_props.sv
`default_nettype none

module comp_unit_props (
   input logic            clk,
   input logic            rst_n,
   input logic            in_eof_n_i,
   input logic            in_src_rdy_n_i,
   input logic            in_dst_rdy_n_o,
   input comp_pkg::word_t out_data_o,
   input logic            out_sof_n_o,
   input logic            out_eof_n_o,
   input logic            out_src_rdy_n_o,
   input logic            out_dst_rdy_n_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // A stalled output word stays put
   a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (!out_src_rdy_n_o && out_dst_rdy_n_i) |=>
      (!out_src_rdy_n_o && $stable(out_data_o) && $stable(out_sof_n_o) &&
       $stable(out_eof_n_o)))
      else $error("output word changed while stalled");

   a_idle_in_reset: assert property (@(posedge clk)
      !rst_n |=> out_src_rdy_n_o)
      else $error("output valid during reset");

   // Input closes right after its eof word
   a_stop_after_eof: assert property (@(posedge clk) disable iff (!rst_n)
      (!in_src_rdy_n_i && !in_dst_rdy_n_o && !in_eof_n_i) |=> in_dst_rdy_n_o)
      else $error("input still ready after the eof word");

endmodule

bind comp_unit comp_unit_props props0 (
   .clk             (clk),
   .rst_n           (rst_n),
   .in_eof_n_i      (in_eof_n_i),
   .in_src_rdy_n_i  (in_src_rdy_n_i),
   .in_dst_rdy_n_o  (in_dst_rdy_n_o),
   .out_data_o      (out_data_o),
   .out_sof_n_o     (out_sof_n_o),
   .out_eof_n_o     (out_eof_n_o),
   .out_src_rdy_n_o (out_src_rdy_n_o),
   .out_dst_rdy_n_i (out_dst_rdy_n_i)
);

`default_nettype wire

// File: bench/tb_comp_unit.sv
`default_nettype none

module tb_comp_unit;

   timeunit 1ns;
   timeprecision 100ps;

   import comp_pkg::*;

   localparam int FIFO_DEPTH = 8;
   localparam int MAX_CASES = 64;
   localparam int RESET_CYCLES = 16;
   localparam logic [31:0] LFSR_SEED = 32'haeabdb01;

   logic  clk;
   logic  rst_n;
   word_t in_data;
   rem_t  in_rem;
   logic  in_sof_n;
   logic  in_eof_n;
   logic  in_src_rdy_n;
   logic  in_dst_rdy_n;
   word_t out_data;
   logic  out_sof_n;
   logic  out_eof_n;
   logic  out_src_rdy_n;
   logic  out_dst_rdy_n;

   // One entry per line of the case file
   flag_t     case_flags [MAX_CASES];
   byte_cnt_t case_len [MAX_CASES];
   task_t     case_task [MAX_CASES];
   int        case_words [MAX_CASES];
   rem_t      case_rem [MAX_CASES];
   int        case_in_rate [MAX_CASES];
   int        case_out_rate [MAX_CASES];
   logic      case_cpl [MAX_CASES];
   int        n_cases;

   // Input words in send order with control {sof_n, eof_n, rem}
   word_t      in_data_q [$];
   logic [5:0] in_ctl_q [$];
   int         in_rate_q [$];

   // Expected output words in order
   word_t exp_data_q [$];
   logic  exp_sof_n_q [$];
   logic  exp_eof_n_q [$];
   int    exp_rate_q [$];
   string exp_what_q [$];

   logic [31:0] lfsr;
   int          cycles;
   int          cycle_limit;
   int          errors;
   int          checks;

   comp_unit #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) dut0 (
      .clk             (clk),
      .rst_n           (rst_n),
      .in_data_i       (in_data),
      .in_rem_i        (in_rem),
      .in_sof_n_i      (in_sof_n),
      .in_eof_n_i      (in_eof_n),
      .in_src_rdy_n_i  (in_src_rdy_n),
      .in_dst_rdy_n_o  (in_dst_rdy_n),
      .out_data_o      (out_data),
      .out_sof_n_o     (out_sof_n),
      .out_eof_n_o     (out_eof_n),
      .out_src_rdy_n_o (out_src_rdy_n),
      .out_dst_rdy_n_i (out_dst_rdy_n)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // Each set bit of the code removes one low-order byte
   function automatic int rem_bytes(input rem_t r);
      return 4 - $countones(r);
   endfunction

   function automatic word_t mask_word(input word_t w, input rem_t r);
      word_t keep;
      keep = 32'hffffffff << (8 * (4 - rem_bytes(r)));
      return w & keep;
   endfunction

   function automatic word_t crc_word(input word_t crc, input word_t d);
      word_t c;
      word_t s;
      logic  fb;
      c = crc;
      s = d;
      repeat (32) begin
         fb = c[31] ^ s[31];
         c = c << 1;
         if (fb)
            c = c ^ CRC_POLY;
         s = s << 1;
      end
      return c;
   endfunction

   task automatic read_cases();
      int          fd;
      int          got;
      string       line;
      logic [31:0] f;
      logic [31:0] len;
      logic [31:0] tsk;
      logic [31:0] words;
      logic [31:0] rem;
      logic [31:0] irate;
      logic [31:0] orate;
      logic [31:0] cpl;
      n_cases = 0;
      fd = $fopen("bench/frame_cases.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Cannot open bench/frame_cases.txt");
         return;
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line[0] == "#")
            continue;
         got = $sscanf(line, "%h %d %h %d %b %d %d %d",
                       f, len, tsk, words, rem, irate, orate, cpl);
         if (got != 8 || words == 0 || n_cases == MAX_CASES) begin
            errors++;
            $display("Case file line not usable: %s", line);
            continue;
         end
         case_flags[n_cases] = f[2:0];
         case_len[n_cases] = len;
         case_task[n_cases] = tsk[9:0];
         case_words[n_cases] = int'(words);
         case_rem[n_cases] = rem[3:0];
         case_in_rate[n_cases] = int'(irate);
         case_out_rate[n_cases] = int'(orate);
         case_cpl[n_cases] = cpl[0];
         n_cases++;
      end
      $fclose(fd);
   endtask

   task automatic queue_input(input word_t d, input logic sof_n, input logic eof_n,
                              input rem_t rem, input int rate);
      in_data_q.push_back(d);
      in_ctl_q.push_back({sof_n, eof_n, rem});
      in_rate_q.push_back(rate);
   endtask

   task automatic expect_word(input word_t d, input logic sof_n, input logic eof_n,
                              input int rate, input string what);
      exp_data_q.push_back(d);
      exp_sof_n_q.push_back(sof_n);
      exp_eof_n_q.push_back(eof_n);
      exp_rate_q.push_back(rate);
      exp_what_q.push_back(what);
   endtask

   // Header, payload and the trailer the model predicts for case c
   task automatic build_frame(input int c);
      logic [31:0] r;
      logic [31:0] junk;
      word_t       w;
      word_t       crc;
      rem_t        rem;
      int          bytes;
      logic        last;
      logic        cpl;
      crc = CRC_INIT;
      bytes = 0;
      for (int i = 0; i < HDR_WORDS; i++) begin
         take_bits(32, r);
         take_bits(4, junk);
         if (i == HDR_FLAG_IDX)
            w = {case_flags[c], r[28:0]};
         else if (i == HDR_LEN_IDX)
            w = case_len[c];
         else if (i == HDR_TASK_IDX)
            w = {r[31:10], case_task[c]};
         else
            w = r;
         queue_input(w, i != 0, 1'b1, junk[3:0], case_in_rate[c]);
      end
      for (int i = 0; i < case_words[c]; i++) begin
         last = (i == case_words[c] - 1);
         take_bits(32, r);
         take_bits(4, junk);
         // Remainder is junk except on the eof word
         rem = last ? case_rem[c] : junk[3:0];
         queue_input(r, 1'b1, !last, rem, case_in_rate[c]);
         w = last ? mask_word(r, rem) : r;
         bytes += last ? rem_bytes(rem) : 4;
         crc = crc_word(crc, w);
         expect_word(w, i != 0, 1'b1, case_out_rate[c], "payload");
      end
      cpl = (byte_cnt_t'(bytes) == case_len[c]);
      if (cpl !== case_cpl[c]) begin
         errors++;
         $display("Case %0d: completion bit in the case file does not match byte count %0d",
                  c, bytes);
      end
      expect_word({case_flags[c], case_cpl[c], 18'd0, case_task[c]}, 1'b1, 1'b1,
                  case_out_rate[c], "status");
      expect_word(byte_cnt_t'(bytes), 1'b1, 1'b1, case_out_rate[c], "byte count");
      expect_word(crc, 1'b1, 1'b1, case_out_rate[c], "crc");
      expect_word(TRL_MARKER, 1'b1, 1'b0, case_out_rate[c], "marker");
   endtask

   task automatic check_output();
      checks++;
      if (out_data !== exp_data_q[0]) begin
         errors++;
         $display("FAILED %0t out_data_o (%s): got %h expected %h",
                  $time, exp_what_q[0], out_data, exp_data_q[0]);
      end
      if (out_sof_n !== exp_sof_n_q[0]) begin
         errors++;
         $display("FAILED %0t out_sof_n_o (%s): got %b expected %b",
                  $time, exp_what_q[0], out_sof_n, exp_sof_n_q[0]);
      end
      if (out_eof_n !== exp_eof_n_q[0]) begin
         errors++;
         $display("FAILED %0t out_eof_n_o (%s): got %b expected %b",
                  $time, exp_what_q[0], out_eof_n, exp_eof_n_q[0]);
      end
      void'(exp_data_q.pop_front());
      void'(exp_sof_n_q.pop_front());
      void'(exp_eof_n_q.pop_front());
      void'(exp_rate_q.pop_front());
      void'(exp_what_q.pop_front());
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Timeout after %0d cycles, limit %0d, checks %0d, errors %0d",
                  cycles, cycle_limit, checks, errors);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      logic [31:0] r;
      logic        in_busy;
      logic        seen_input;
      in_data = '0;
      in_rem = '0;
      in_sof_n = 1'b1;
      in_eof_n = 1'b1;
      in_src_rdy_n = 1'b1;
      out_dst_rdy_n = 1'b1;
      rst_n = 1'b0;
      lfsr = LFSR_SEED;
      cycles = 0;
      errors = 0;
      checks = 0;
      in_busy = 1'b0;
      seen_input = 1'b0;
      read_cases();
      cycle_limit = RESET_CYCLES;
      for (int c = 0; c < n_cases; c++) begin
         build_frame(c);
         cycle_limit += 8 * (HDR_WORDS + case_words[c] + TRL_WORDS) + 100;
      end

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      checks++;
      if (in_dst_rdy_n !== 1'b1) begin
         errors++;
         $display("FAILED %0t in_dst_rdy_n_o: got %b expected 1", $time, in_dst_rdy_n);
      end
      if (out_src_rdy_n !== 1'b1) begin
         errors++;
         $display("FAILED %0t out_src_rdy_n_o: got %b expected 1", $time, out_src_rdy_n);
      end
      if (out_sof_n !== 1'b1) begin
         errors++;
         $display("FAILED %0t out_sof_n_o: got %b expected 1", $time, out_sof_n);
      end
      if (out_eof_n !== 1'b1) begin
         errors++;
         $display("FAILED %0t out_eof_n_o: got %b expected 1", $time, out_eof_n);
      end
      @(posedge clk);
      #1;

      while (exp_data_q.size() > 0) begin
         if (!in_busy) begin
            in_src_rdy_n = 1'b1;
            if (in_data_q.size() > 0) begin
               take_bits(4, r);
               if (int'(r[3:0]) >= in_rate_q[0]) begin
                  in_data = in_data_q[0];
                  {in_sof_n, in_eof_n, in_rem} = in_ctl_q[0];
                  in_src_rdy_n = 1'b0;
                  in_busy = 1'b1;
               end
            end
         end
         take_bits(4, r);
         out_dst_rdy_n = (int'(r[3:0]) < exp_rate_q[0]);

         // Handshakes are settled by the falling edge
         @(negedge clk);
         if (in_busy && !in_dst_rdy_n) begin
            void'(in_data_q.pop_front());
            void'(in_ctl_q.pop_front());
            void'(in_rate_q.pop_front());
            in_busy = 1'b0;
            seen_input = 1'b1;
         end
         if (!out_src_rdy_n && !out_dst_rdy_n) begin
            if (!seen_input) begin
               errors++;
               $display("Output word %h taken at %0t before any input word", out_data, $time);
            end
            check_output();
         end
         @(posedge clk);
         #1;
      end

      in_src_rdy_n = 1'b1;
      out_dst_rdy_n = 1'b0;
      repeat (4 * FIFO_DEPTH) begin
         @(negedge clk);
         if (!out_src_rdy_n) begin
            errors++;
            $display("Extra output word %h at %0t after the last frame", out_data, $time);
         end
         @(posedge clk);
         #1;
      end

      $display("Frames %0d, checks %0d, errors %0d", n_cases, checks, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: bench/frame_cases.txt
# flags(hex) length(dec) task(hex) words(dec) rem(bin) in_stall out_stall cpl
# stalls in 1/16ths, cpl is 1 when length equals the payload byte count
5 4 001 1 0000 0 0 1
2 3 3ff 1 0001 0 0 1
7 17 123 5 0111 2 2 1
0 40 0aa 10 0000 4 4 1
1 39 155 10 0000 4 4 0
3 30 2c4 8 0011 0 14 1
4 64 001 16 0000 0 15 1
6 63 0f0 16 0001 8 12 1
1 100 3a5 25 0000 12 0 1
2 10 044 3 0111 0 0 0
5 2 011 1 0011 3 3 1
7 1 200 1 0111 15 15 1
0 0 000 2 0000 0 0 0
3 120 1ff 30 0000 6 13 1
6 47 333 12 0001 10 10 1
4 22 0c3 6 0011 1 15 1
2 33 2a2 9 0111 5 0 1

// File: project.f
source/comp_pkg.sv
source/frame_ctrl.sv
source/beat_counter.sv
source/payload_fifo.sv
source/crc32_acc.sv
source/trailer_builder.sv
source/comp_unit.sv
bench/comp_unit_props.sv
bench/tb_comp_unit.sv

// File: Makefile
# Verilator build and run for the framed-stream copy unit

VERILATOR  ?= verilator
TOP        ?= tb_comp_unit
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
SOURCES    := $(wildcard source/*.sv bench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
